/* hpa_lcd_top.f */
+incdir+rtl
rtl/hpa_pkg.sv
rtl/rst_sequencer.sv
rtl/lcd_timing.sv
rtl/pattern_gen.sv
rtl/hpa_lcd_top.sv
tb/tb_hpa_lcd_top.sv

/* rtl/hpa_lcd_top.sv */
`timescale 1ns/1ps
`include "hpa_params.svh"

module hpa_lcd_top (
    input  logic                        clk245760,
    input  logic                        rst,
    output logic [`HPA_COLOR_WIDTH-1:0] lcd_r_o,
    output logic [`HPA_COLOR_WIDTH-1:0] lcd_g_o,
    output logic [`HPA_COLOR_WIDTH-1:0] lcd_b_o,
    output logic                        lcd_hsync_o,
    output logic                        lcd_vsync_o,
    output logic                        lcd_de_o,
    output logic                        lcd_nclk_o
);

    logic              rst_ip;
    logic              pop;
    logic              ack;
    hpa_pkg::lcd_pos_t pos;
    hpa_pkg::rgb666_t  rgb;

    rst_sequencer u_rst_sequencer (
        .clk245760 (clk245760),
        .rst       (rst),
        .rst_ip_o  (rst_ip)
    );

    // panel timing pulls pixels from the pattern source
    lcd_timing u_lcd_timing (
        .clk245760   (clk245760),
        .rst_ip_i    (rst_ip),
        .ack_i       (ack),
        .rgb_i       (rgb),
        .pop_o       (pop),
        .pos_o       (pos),
        .lcd_r_o     (lcd_r_o),
        .lcd_g_o     (lcd_g_o),
        .lcd_b_o     (lcd_b_o),
        .lcd_hsync_o (lcd_hsync_o),
        .lcd_vsync_o (lcd_vsync_o),
        .lcd_de_o    (lcd_de_o),
        .lcd_nclk_o  (lcd_nclk_o)
    );

    pattern_gen u_pattern_gen (
        .clk245760 (clk245760),
        .rst_ip_i  (rst_ip),
        .pop_i     (pop),
        .pos_i     (pos),
        .ack_o     (ack),
        .rgb_o     (rgb)
    );

endmodule

/* rtl/hpa_params.svh */
`ifndef HPA_PARAMS_SVH
`define HPA_PARAMS_SVH

// panel geometry, horizontal in pixels
`define HPA_H_ACTIVE 480
`define HPA_H_FP 2
`define HPA_H_SYNC 41
`define HPA_H_BP 2
`define HPA_H_TOTAL (`HPA_H_ACTIVE + `HPA_H_FP + `HPA_H_SYNC + `HPA_H_BP)

// panel geometry, vertical in lines
`define HPA_V_ACTIVE 272
`define HPA_V_FP 2
`define HPA_V_SYNC 10
`define HPA_V_BP 2
`define HPA_V_TOTAL (`HPA_V_ACTIVE + `HPA_V_FP + `HPA_V_SYNC + `HPA_V_BP)

// clock cycles per pixel slot
`define HPA_PIXEL_DIV 4
`define HPA_PHASE_WIDTH 2

`define HPA_RST_DELAY 63
`define HPA_RST_CNT_WIDTH 6

// field and counter widths
`define HPA_X_WIDTH 9
`define HPA_Y_WIDTH 9
`define HPA_H_CNT_WIDTH 10
`define HPA_V_CNT_WIDTH 9
`define HPA_COLOR_WIDTH 6
`define HPA_BAR_WIDTH 60

`endif

/* rtl/hpa_pkg.sv */
`include "hpa_params.svh"

package hpa_pkg;

    // pixel position as requested from the pixel source
    typedef struct packed {
        logic [`HPA_X_WIDTH-1:0] x;
        logic [`HPA_Y_WIDTH-1:0] y;
    } lcd_pos_t;

    // one RGB666 pixel
    typedef struct packed {
        logic [`HPA_COLOR_WIDTH-1:0] r;
        logic [`HPA_COLOR_WIDTH-1:0] g;
        logic [`HPA_COLOR_WIDTH-1:0] b;
    } rgb666_t;

    // panel control, syncs are active low
    typedef struct packed {
        logic hsync_n;
        logic vsync_n;
        logic de;
    } lcd_sync_t;

    // blanking state of the panel controls
    localparam lcd_sync_t lcd_sync_idle = '{
        hsync_n: 1'b1,
        vsync_n: 1'b1,
        de: 1'b0
    };

endpackage

/* rtl/lcd_timing.sv */
`timescale 1ns/1ps
`include "hpa_params.svh"

module lcd_timing (
    input  logic                        clk245760,
    input  logic                        rst_ip_i,
    input  logic                        ack_i,
    input  hpa_pkg::rgb666_t            rgb_i,
    output logic                        pop_o,
    output hpa_pkg::lcd_pos_t           pos_o,
    output logic [`HPA_COLOR_WIDTH-1:0] lcd_r_o,
    output logic [`HPA_COLOR_WIDTH-1:0] lcd_g_o,
    output logic [`HPA_COLOR_WIDTH-1:0] lcd_b_o,
    output logic                        lcd_hsync_o,
    output logic                        lcd_vsync_o,
    output logic                        lcd_de_o,
    output logic                        lcd_nclk_o
);

    logic [`HPA_PHASE_WIDTH-1:0] phase;
    logic [`HPA_PHASE_WIDTH-1:0] phase_next;
    logic                        slot_end;
    logic [`HPA_H_CNT_WIDTH-1:0] h_cnt;
    logic [`HPA_V_CNT_WIDTH-1:0] v_cnt;
    hpa_pkg::lcd_sync_t          sync_cur;
    hpa_pkg::lcd_sync_t          sync_q;
    hpa_pkg::lcd_sync_t          pin_sync;
    hpa_pkg::rgb666_t            pix_q;
    hpa_pkg::rgb666_t            pix_sel;
    hpa_pkg::rgb666_t            pin_rgb;
    logic                        got_ack;
    logic                        pix_valid;

    assign slot_end = (phase == `HPA_PHASE_WIDTH'(`HPA_PIXEL_DIV - 1));
    assign phase_next = slot_end ? '0 : phase + 1'b1;

    // starts on the last phase so the first cycle after release loads 0,0
    always_ff @(posedge clk245760) begin
        if (rst_ip_i) begin
            phase <= `HPA_PHASE_WIDTH'(`HPA_PIXEL_DIV - 1);
        end else begin
            phase <= phase_next;
        end
    end

    // nclk low in the first half of a slot, high in the second
    always_ff @(posedge clk245760) begin
        if (rst_ip_i) begin
            lcd_nclk_o <= 1'b0;
        end else begin
            lcd_nclk_o <= (phase_next >= `HPA_PHASE_WIDTH'(`HPA_PIXEL_DIV / 2));
        end
    end

    // h_cnt/v_cnt hold the position requested in the coming slot
    always_ff @(posedge clk245760) begin
        if (rst_ip_i) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (slot_end) begin
            if (h_cnt == `HPA_H_CNT_WIDTH'(`HPA_H_TOTAL - 1)) begin
                h_cnt <= '0;
                if (v_cnt == `HPA_V_CNT_WIDTH'(`HPA_V_TOTAL - 1)) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // active region first, then front porch, sync and back porch
    always_comb begin
        sync_cur.hsync_n = !((h_cnt >= (`HPA_H_ACTIVE + `HPA_H_FP))
            && (h_cnt < (`HPA_H_ACTIVE + `HPA_H_FP + `HPA_H_SYNC)));
        sync_cur.vsync_n = !((v_cnt >= (`HPA_V_ACTIVE + `HPA_V_FP))
            && (v_cnt < (`HPA_V_ACTIVE + `HPA_V_FP + `HPA_V_SYNC)));
        sync_cur.de = (h_cnt < `HPA_H_ACTIVE) && (v_cnt < `HPA_V_ACTIVE);
    end

    // position only matters while pop is high
    always_ff @(posedge clk245760) begin
        if (slot_end) begin
            pos_o <= '{
                x: h_cnt[`HPA_X_WIDTH-1:0],
                y: v_cnt[`HPA_Y_WIDTH-1:0]
            };
        end
    end

    // returned pixel for the slot in flight
    always_ff @(posedge clk245760) begin
        if (ack_i) begin
            pix_q <= rgb_i;
        end
    end

    always_ff @(posedge clk245760) begin
        if (rst_ip_i) begin
            got_ack <= 1'b0;
        end else if (slot_end) begin
            got_ack <= 1'b0;
        end else if (ack_i) begin
            got_ack <= 1'b1;
        end
    end

    // a late ack in the last cycle of the slot still counts
    assign pix_sel = ack_i ? rgb_i : pix_q;
    assign pix_valid = got_ack || ack_i;

    // request goes out one slot ahead, pins update at the slot boundary
    always_ff @(posedge clk245760) begin
        if (rst_ip_i) begin
            pop_o <= 1'b0;
            sync_q <= hpa_pkg::lcd_sync_idle;
            pin_sync <= hpa_pkg::lcd_sync_idle;
            pin_rgb <= '0;
        end else if (slot_end) begin
            pop_o <= sync_cur.de;
            sync_q <= sync_cur;
            pin_sync <= sync_q;
            // black when the source missed its slot
            pin_rgb <= (pix_valid && sync_q.de) ? pix_sel : '0;
        end else begin
            pop_o <= 1'b0;
        end
    end

    assign lcd_r_o = pin_rgb.r;
    assign lcd_g_o = pin_rgb.g;
    assign lcd_b_o = pin_rgb.b;
    assign lcd_hsync_o = pin_sync.hsync_n;
    assign lcd_vsync_o = pin_sync.vsync_n;
    assign lcd_de_o = pin_sync.de;

endmodule

/* rtl/pattern_gen.sv */
`timescale 1ns/1ps
`include "hpa_params.svh"

module pattern_gen (
    input  logic              clk245760,
    input  logic              rst_ip_i,
    input  logic              pop_i,
    input  hpa_pkg::lcd_pos_t pos_i,
    output logic              ack_o,
    output hpa_pkg::rgb666_t  rgb_o
);

    logic             border;
    // eight bars across the visible width
    logic [2:0]       bar;
    hpa_pkg::rgb666_t pix;

    // outermost visible rows and columns
    assign border = (pos_i.x == '0)
        || (pos_i.x == `HPA_X_WIDTH'(`HPA_H_ACTIVE - 1))
        || (pos_i.y == '0)
        || (pos_i.y == `HPA_Y_WIDTH'(`HPA_V_ACTIVE - 1));

    // bar index by threshold compares, no divider
    always_comb begin
        bar = '0;
        for (int i = 1; i < `HPA_H_ACTIVE / `HPA_BAR_WIDTH; i++) begin
            if (pos_i.x >= `HPA_X_WIDTH'(i * `HPA_BAR_WIDTH)) begin
                bar = bar + 1'b1;
            end
        end
    end

    always_comb begin
        if (border) begin
            pix = '1;
        end else begin
            pix.r = {`HPA_COLOR_WIDTH{bar[2]}};
            pix.g = {`HPA_COLOR_WIDTH{bar[1]}};
            pix.b = {`HPA_COLOR_WIDTH{bar[0]}};
        end
    end

    // one cycle from pop to ack
    always_ff @(posedge clk245760) begin
        if (rst_ip_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= pop_i;
        end
    end

    always_ff @(posedge clk245760) begin
        if (pop_i) begin
            rgb_o <= pix;
        end
    end

endmodule

/* rtl/rst_sequencer.sv */
`timescale 1ns/1ps
`include "hpa_params.svh"

module rst_sequencer (
    input  logic clk245760,
    input  logic rst,
    output logic rst_ip_o
);

    logic [`HPA_RST_CNT_WIDTH-1:0] delay_cnt;
    logic                          delay_done;

    assign delay_done = (delay_cnt == `HPA_RST_CNT_WIDTH'(`HPA_RST_DELAY));

    // saturating delay counter
    always_ff @(posedge clk245760) begin
        if (rst) begin
            delay_cnt <= '0;
        end else if (!delay_done) begin
            delay_cnt <= delay_cnt + 1'b1;
        end
    end

    // registered so the release lands exactly on the delay
    always_ff @(posedge clk245760) begin
        if (rst) begin
            rst_ip_o <= 1'b1;
        end else begin
            rst_ip_o <= !delay_done;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and judge the result from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f hpa_lcd_top.f \
    --top-module tb_hpa_lcd_top > build.log 2>&1 \
    && ./obj_dir/Vtb_hpa_lcd_top > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation run failed"; exit 1; }
cat sim.log
! grep -q "Test FAILED" sim.log && grep -q "Test OK" sim.log

/* tb/tb_hpa_lcd_top.sv */
`timescale 1ns/1ps
`include "hpa_params.svh"

module tb_hpa_lcd_top;

    localparam int CLK_PERIOD_NS = 4;
    localparam int LINE_PIXELS = `HPA_H_TOTAL;
    localparam int LINE_CYCLES = LINE_PIXELS * `HPA_PIXEL_DIV;
    localparam int FRAME_CYCLES = `HPA_V_TOTAL * LINE_CYCLES;
    // nclk starts toggling four cycles after the internal reset window
    localparam int SETTLE = `HPA_RST_DELAY + 4;
    localparam int WATCHDOG_NS = (3 * FRAME_CYCLES + 20 * LINE_CYCLES) * CLK_PERIOD_NS;

    logic                        clk245760;
    logic                        rst;
    logic [`HPA_COLOR_WIDTH-1:0] lcd_r;
    logic [`HPA_COLOR_WIDTH-1:0] lcd_g;
    logic [`HPA_COLOR_WIDTH-1:0] lcd_b;
    logic                        lcd_hsync;
    logic                        lcd_vsync;
    logic                        lcd_de;
    logic                        lcd_nclk;
    hpa_pkg::lcd_sync_t          pin_sync;
    hpa_pkg::rgb666_t            pin_rgb;
    logic [$bits(hpa_pkg::lcd_sync_t)+$bits(hpa_pkg::rgb666_t)-1:0] pins;
    integer                      seed = 32'h57d93069;
    int                          rst_age = 0;
    int                          rel_cnt = 0;
    logic                        rst_check;
    logic                        steady;

    // line and frame measurement, in pixels
    int   since_hs, since_vs, since_de;
    int   de_run, hs_run, vs_run;
    int   de_lines, cur_y;
    logic nclk_prev, de_prev, hs_prev, vs_prev;
    logic line_has_de, hs_seen, vs_armed;
    int   errors = 0;
    int   lines_checked = 0;
    int   frames_checked = 0;

    hpa_lcd_top DUT (
        .clk245760   (clk245760),
        .rst         (rst),
        .lcd_r_o     (lcd_r),
        .lcd_g_o     (lcd_g),
        .lcd_b_o     (lcd_b),
        .lcd_hsync_o (lcd_hsync),
        .lcd_vsync_o (lcd_vsync),
        .lcd_de_o    (lcd_de),
        .lcd_nclk_o  (lcd_nclk)
    );

    assign pin_sync = {lcd_hsync, lcd_vsync, lcd_de};
    assign pin_rgb = {lcd_r, lcd_g, lcd_b};
    assign pins = {pin_sync, pin_rgb};
    // pins go idle two cycles after rst rises
    assign rst_check = rst ? (rst_age >= 2) : (rel_cnt <= `HPA_RST_DELAY);
    assign steady = !rst && (rel_cnt >= SETTLE);

    task automatic report_mismatch(input string name, input int got, input int exp);
        errors = errors + 1;
        $display("Error at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
    endtask

    task automatic record_failure(input string msg);
        errors = errors + 1;
        $display("At %0d ns: %s", $time, msg);
    endtask

    // border is white, inside it eight bars of 60 pixels
    function automatic hpa_pkg::rgb666_t expected_rgb(input int x, input int y);
        hpa_pkg::rgb666_t pix;
        int               bar;
        bar = x / `HPA_BAR_WIDTH;
        pix.r = bar[2] ? {`HPA_COLOR_WIDTH{1'b1}} : '0;
        pix.g = bar[1] ? {`HPA_COLOR_WIDTH{1'b1}} : '0;
        pix.b = bar[0] ? {`HPA_COLOR_WIDTH{1'b1}} : '0;
        if (x == 0 || x == `HPA_H_ACTIVE - 1 || y == 0 || y == `HPA_V_ACTIVE - 1) begin
            pix = '1;
        end
        return pix;
    endfunction

    initial begin
        clk245760 = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk245760 = ~clk245760;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the last frame was measured");
        $display("Test FAILED");
        $finish;
    end

    always @(posedge clk245760) begin
        if (rst) begin
            rel_cnt <= 0;
            rst_age <= (rst_age < 2) ? rst_age + 1 : rst_age;
        end else begin
            rst_age <= 0;
            rel_cnt <= (rel_cnt < SETTLE) ? rel_cnt + 1 : rel_cnt;
        end
    end

    reset_syncs_idle: assert property (@(negedge clk245760)
        rst_check |-> ({pin_sync, lcd_nclk} == 4'b1100))
        else report_mismatch("{hsync,vsync,de,nclk} in reset", {pin_sync, lcd_nclk}, 4'b1100);
    reset_rgb_black: assert property (@(negedge clk245760) rst_check |-> (pin_rgb == '0))
        else report_mismatch("lcd rgb in reset", pin_rgb, 0);
    nclk_period: assert property (@(negedge clk245760) disable iff (!steady)
        lcd_nclk == !$past(lcd_nclk, 2))
        else report_mismatch("lcd_nclk_o", lcd_nclk, !lcd_nclk);
    pins_on_nclk_fall: assert property (@(negedge clk245760) disable iff (!steady)
        (pins != $past(pins)) |-> (!lcd_nclk && $past(lcd_nclk)))
        else record_failure("panel outputs changed away from a falling edge of lcd_nclk_o");
    blank_rgb_black: assert property (@(negedge clk245760) disable iff (!steady)
        !pin_sync.de |-> (pin_rgb == '0))
        else report_mismatch("lcd rgb while de is low", pin_rgb, 0);

    // one step per pixel, at each falling edge of nclk
    always @(negedge clk245760) begin
        if (!steady) begin
            since_hs = 0;
            since_vs = 0;
            since_de = 0;
            de_run = 0;
            hs_run = 0;
            vs_run = 0;
            de_lines = 0;
            cur_y = 0;
            de_prev = 1'b0;
            hs_prev = 1'b1;
            vs_prev = 1'b1;
            line_has_de = 1'b0;
            hs_seen = 1'b0;
            vs_armed = 1'b0;
        end else if (!lcd_nclk && nclk_prev) begin
            since_hs = since_hs + 1;
            since_vs = since_vs + 1;
            since_de = since_de + 1;
            if (pin_sync.de && !de_prev) begin
                if (vs_armed) begin
                    assert (since_vs == `HPA_V_BP * LINE_PIXELS)
                        else report_mismatch("pixels from vsync end to de", since_vs,
                            `HPA_V_BP * LINE_PIXELS);
                    frames_checked = frames_checked + 1;
                    vs_armed = 1'b0;
                end
                since_de = 0;
                line_has_de = 1'b1;
                cur_y = de_lines;
                de_lines = de_lines + 1;
            end
            if (pin_sync.de) begin
                de_run = de_run + 1;
                assert (pin_rgb == expected_rgb(since_de, cur_y))
                    else report_mismatch("lcd rgb", pin_rgb, expected_rgb(since_de, cur_y));
            end else if (de_prev) begin
                assert (de_run == `HPA_H_ACTIVE)
                    else report_mismatch("lcd_de_o pixels per line", de_run, `HPA_H_ACTIVE);
                de_run = 0;
                lines_checked = lines_checked + 1;
            end
            if (!pin_sync.hsync_n && hs_prev) begin
                assert (!line_has_de || since_de == `HPA_H_ACTIVE + `HPA_H_FP)
                    else report_mismatch("pixels from de rise to hsync", since_de,
                        `HPA_H_ACTIVE + `HPA_H_FP);
                assert (!hs_seen || since_hs == LINE_PIXELS)
                    else report_mismatch("pixels between hsync falls", since_hs, LINE_PIXELS);
                line_has_de = 1'b0;
                hs_seen = 1'b1;
                since_hs = 0;
            end
            if (!pin_sync.hsync_n) begin
                hs_run = hs_run + 1;
            end else if (!hs_prev) begin
                assert (hs_run == `HPA_H_SYNC)
                    else report_mismatch("lcd_hsync_o low pixels", hs_run, `HPA_H_SYNC);
                hs_run = 0;
            end
            if (!pin_sync.vsync_n && vs_prev) begin
                assert (de_lines == `HPA_V_ACTIVE)
                    else report_mismatch("active lines per frame", de_lines, `HPA_V_ACTIVE);
            end
            if (!pin_sync.vsync_n) begin
                vs_run = vs_run + 1;
            end else if (!vs_prev) begin
                assert (vs_run == `HPA_V_SYNC * LINE_PIXELS)
                    else report_mismatch("lcd_vsync_o low pixels", vs_run,
                        `HPA_V_SYNC * LINE_PIXELS);
                vs_run = 0;
                vs_armed = 1'b1;
                since_vs = 0;
                de_lines = 0;
            end
            de_prev = pin_sync.de;
            hs_prev = pin_sync.hsync_n;
            vs_prev = pin_sync.vsync_n;
        end
        nclk_prev = lcd_nclk;
    end

    initial begin
        int offset;
        int frames_before;
        rst = 1'b1;
        repeat (4) @(posedge clk245760);
        rst <= 1'b0;
        // second reset lands somewhere inside the second frame
        offset = LINE_CYCLES + ($unsigned($random(seed)) % (FRAME_CYCLES - 2 * LINE_CYCLES));
        repeat (FRAME_CYCLES + offset) @(posedge clk245760);
        rst <= 1'b1;
        repeat (4) @(posedge clk245760);
        rst <= 1'b0;
        frames_before = frames_checked;
        wait (frames_checked > frames_before);
        repeat (4) @(posedge clk245760);
        if (frames_checked < 2) begin
            record_failure("fewer than two frames were measured");
        end
        $display("summary: %0d errors, %0d lines and %0d frames checked",
            errors, lines_checked, frames_checked);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
